// File: design/lsu_pkg.sv
package lsu_pkg;

  // ------------------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------------------
  localparam int unsigned XLEN       = 32;
  localparam int unsigned NBYTES     = XLEN / 8;
  localparam int unsigned TRANS_ID_W = 3;

  // ------------------------------------------------------------------------
  // Operations
  // ------------------------------------------------------------------------
  // Loads first, stores after
  typedef enum logic [3:0] {
    LB  = 4'd0,
    LBU = 4'd1,
    LH  = 4'd2,
    LHU = 4'd3,
    LW  = 4'd4,
    SB  = 4'd5,
    SH  = 4'd6,
    SW  = 4'd7
  } lsu_op_e;

  // ------------------------------------------------------------------------
  // Memory sequencer
  // ------------------------------------------------------------------------
  // IDLE          waiting for a slot
  // REQ           req high, waiting for ack
  // WAIT_ACK_LOW  req dropped, waiting for ack to fall
  // DONE          one-cycle result pulse
  typedef enum logic [1:0] {
    IDLE         = 2'd0,
    REQ          = 2'd1,
    WAIT_ACK_LOW = 2'd2,
    DONE         = 2'd3
  } mem_state_e;

endpackage

// File: design/lsu_load_align.sv
`timescale 1ns/1ns

module lsu_load_align (
  input  lsu_pkg::lsu_op_e          op_i,
  input  logic [1:0]                addr_lsb_i,
  input  logic [lsu_pkg::XLEN-1:0]  rdata_i,
  output logic [lsu_pkg::XLEN-1:0]  result_o
);

  import lsu_pkg::*;

  logic [XLEN-1:0] shifted;

  // Addressed byte or halfword moved down to lane 0
  assign shifted = rdata_i >> {addr_lsb_i, 3'b000};

  always_comb begin
    unique case (op_i)
      LB: begin
        result_o = {{(XLEN - 8){shifted[7]}}, shifted[7:0]};
      end
      LBU: begin
        result_o = {{(XLEN - 8){1'b0}}, shifted[7:0]};
      end
      LH: begin
        result_o = {{(XLEN - 16){shifted[15]}}, shifted[15:0]};
      end
      LHU: begin
        result_o = {{(XLEN - 16){1'b0}}, shifted[15:0]};
      end
      // LW and anything else pass the word unchanged
      default: begin
        result_o = rdata_i;
      end
    endcase
  end

endmodule

// File: design/lsu_agu.sv
`timescale 1ns/1ns

module lsu_agu (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            lsu_valid_i,
  input  lsu_pkg::lsu_op_e                op_i,
  input  logic [lsu_pkg::XLEN-1:0]        operand_a_i,
  input  logic [lsu_pkg::XLEN-1:0]        imm_i,
  input  logic [lsu_pkg::XLEN-1:0]        operand_b_i,
  input  logic [lsu_pkg::TRANS_ID_W-1:0]  trans_id_i,
  input  logic                            take_i,
  output logic                            lsu_ready_o,
  output logic                            slot_valid_o,
  output lsu_pkg::lsu_op_e                slot_op_o,
  output logic [lsu_pkg::XLEN-1:0]        slot_addr_o,
  output logic [lsu_pkg::NBYTES-1:0]      slot_be_o,
  output logic [lsu_pkg::XLEN-1:0]        slot_wdata_o,
  output logic [lsu_pkg::TRANS_ID_W-1:0]  slot_trans_id_o,
  output logic                            slot_misaligned_o
);

  import lsu_pkg::*;

  logic [XLEN-1:0]   addr;
  logic [1:0]        size;
  logic [NBYTES-1:0] be;
  logic [XLEN-1:0]   wdata;
  logic              misaligned;
  logic              accept;
  logic              full_q;
  logic              ready_en_q;

  // ------------------------------------------------------------------------
  // Address, size, byte enables
  // ------------------------------------------------------------------------
  assign addr = operand_a_i + imm_i;

  // 0 byte, 1 halfword, 2 word
  always_comb begin
    unique case (op_i)
      LB, LBU, SB: size = 2'd0;
      LH, LHU, SH: size = 2'd1;
      default:     size = 2'd2;
    endcase
  end

  always_comb begin
    unique case (size)
      2'd0:    be = 4'b0001 << addr[1:0];
      2'd1:    be = 4'b0011 << addr[1:0];
      default: be = 4'b1111;
    endcase
  end

  // Store data into its byte lanes
  assign wdata = operand_b_i << {addr[1:0], 3'b000};

  assign misaligned = ((size == 2'd1) && addr[0]) ||
                      ((size == 2'd2) && (addr[1:0] != 2'b00));

  // ------------------------------------------------------------------------
  // One-entry request register
  // ------------------------------------------------------------------------
  assign lsu_ready_o = ready_en_q && (!full_q || take_i);
  assign accept      = lsu_valid_i && lsu_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q     <= 1'b0;
      ready_en_q <= 1'b0;
    end else begin
      ready_en_q <= 1'b1;
      if (accept) begin
        full_q <= 1'b1;
      end else if (take_i) begin
        full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      slot_op_o         <= op_i;
      slot_addr_o       <= addr;
      slot_be_o         <= be;
      slot_wdata_o      <= wdata;
      slot_trans_id_o   <= trans_id_i;
      slot_misaligned_o <= misaligned;
    end
  end

  assign slot_valid_o = full_q;

endmodule

// File: design/lsu_mem_ctrl.sv
`timescale 1ns/1ns

module lsu_mem_ctrl (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            slot_valid_i,
  input  lsu_pkg::lsu_op_e                slot_op_i,
  input  logic [lsu_pkg::XLEN-1:0]        slot_addr_i,
  input  logic [lsu_pkg::NBYTES-1:0]      slot_be_i,
  input  logic [lsu_pkg::XLEN-1:0]        slot_wdata_i,
  input  logic [lsu_pkg::TRANS_ID_W-1:0]  slot_trans_id_i,
  input  logic                            slot_misaligned_i,
  input  logic                            mem_ack_i,
  input  logic [lsu_pkg::XLEN-1:0]        mem_rdata_i,
  output logic                            take_o,
  output logic                            mem_req_o,
  output logic                            mem_we_o,
  output logic [lsu_pkg::XLEN-1:0]        mem_addr_o,
  output logic [lsu_pkg::NBYTES-1:0]      mem_be_o,
  output logic [lsu_pkg::XLEN-1:0]        mem_wdata_o,
  output logic                            load_valid_o,
  output logic                            load_ex_o,
  output logic [lsu_pkg::TRANS_ID_W-1:0]  load_trans_id_o,
  output logic [lsu_pkg::XLEN-1:0]        load_result_o,
  output logic                            store_valid_o,
  output logic                            store_ex_o,
  output logic [lsu_pkg::TRANS_ID_W-1:0]  store_trans_id_o,
  output logic [lsu_pkg::XLEN-1:0]        store_result_o
);

  import lsu_pkg::*;

  mem_state_e            state_q;
  mem_state_e            state_d;
  lsu_op_e               op_q;
  logic [XLEN-1:0]       addr_q;
  logic [NBYTES-1:0]     be_q;
  logic [XLEN-1:0]       wdata_q;
  logic [TRANS_ID_W-1:0] trans_id_q;
  logic                  misaligned_q;
  logic [XLEN-1:0]       rdata_q;
  logic [XLEN-1:0]       load_value;
  logic                  is_store;
  logic                  done;

  assign is_store = op_q inside {SB, SH, SW};
  assign take_o   = (state_q == IDLE) && slot_valid_i;
  assign done     = (state_q == DONE);

  // ------------------------------------------------------------------------
  // Four-phase sequencer
  // ------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        // Misaligned slots never touch memory
        if (slot_valid_i) begin
          state_d = slot_misaligned_i ? DONE : REQ;
        end
      end
      REQ: begin
        if (mem_ack_i) begin
          state_d = WAIT_ACK_LOW;
        end
      end
      WAIT_ACK_LOW: begin
        if (!mem_ack_i) begin
          state_d = DONE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_o) begin
      op_q         <= slot_op_i;
      addr_q       <= slot_addr_i;
      be_q         <= slot_be_i;
      wdata_q      <= slot_wdata_i;
      trans_id_q   <= slot_trans_id_i;
      misaligned_q <= slot_misaligned_i;
    end
    // Read word captured on the ack edge
    if ((state_q == REQ) && mem_ack_i) begin
      rdata_q <= mem_rdata_i;
    end
  end

  assign mem_req_o   = (state_q == REQ);
  assign mem_we_o    = is_store;
  assign mem_addr_o  = {addr_q[XLEN-1:2], 2'b00};
  assign mem_be_o    = be_q;
  assign mem_wdata_o = wdata_q;

  // ------------------------------------------------------------------------
  // Results
  // ------------------------------------------------------------------------
  lsu_load_align u_load_align (
    .op_i       (op_q),
    .addr_lsb_i (addr_q[1:0]),
    .rdata_i    (rdata_q),
    .result_o   (load_value)
  );

  assign load_valid_o     = done && !is_store;
  assign load_ex_o        = done && !is_store && misaligned_q;
  assign load_trans_id_o  = trans_id_q;
  assign load_result_o    = misaligned_q ? addr_q : load_value;

  // Faulting address on exception, zero otherwise
  assign store_valid_o    = done && is_store;
  assign store_ex_o       = done && is_store && misaligned_q;
  assign store_trans_id_o = trans_id_q;
  assign store_result_o   = misaligned_q ? addr_q : '0;

endmodule

// File: design/lsu_top.sv
`timescale 1ns/1ns

module lsu_top (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // Issue side
  input  logic                            lsu_valid_i,
  output logic                            lsu_ready_o,
  input  lsu_pkg::lsu_op_e                op_i,
  input  logic [lsu_pkg::XLEN-1:0]        operand_a_i,
  input  logic [lsu_pkg::XLEN-1:0]        imm_i,
  input  logic [lsu_pkg::XLEN-1:0]        operand_b_i,
  input  logic [lsu_pkg::TRANS_ID_W-1:0]  trans_id_i,
  // Memory side
  output logic                            mem_req_o,
  output logic                            mem_we_o,
  output logic [lsu_pkg::XLEN-1:0]        mem_addr_o,
  output logic [lsu_pkg::NBYTES-1:0]      mem_be_o,
  output logic [lsu_pkg::XLEN-1:0]        mem_wdata_o,
  input  logic                            mem_ack_i,
  input  logic [lsu_pkg::XLEN-1:0]        mem_rdata_i,
  // Results
  output logic                            load_valid_o,
  output logic                            load_ex_o,
  output logic [lsu_pkg::TRANS_ID_W-1:0]  load_trans_id_o,
  output logic [lsu_pkg::XLEN-1:0]        load_result_o,
  output logic                            store_valid_o,
  output logic                            store_ex_o,
  output logic [lsu_pkg::TRANS_ID_W-1:0]  store_trans_id_o,
  output logic [lsu_pkg::XLEN-1:0]        store_result_o
);

  import lsu_pkg::*;

  logic                  slot_valid;
  lsu_op_e               slot_op;
  logic [XLEN-1:0]       slot_addr;
  logic [NBYTES-1:0]     slot_be;
  logic [XLEN-1:0]       slot_wdata;
  logic [TRANS_ID_W-1:0] slot_trans_id;
  logic                  slot_misaligned;
  logic                  take;

  lsu_agu u_agu (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lsu_valid_i       (lsu_valid_i),
    .op_i              (op_i),
    .operand_a_i       (operand_a_i),
    .imm_i             (imm_i),
    .operand_b_i       (operand_b_i),
    .trans_id_i        (trans_id_i),
    .take_i            (take),
    .lsu_ready_o       (lsu_ready_o),
    .slot_valid_o      (slot_valid),
    .slot_op_o         (slot_op),
    .slot_addr_o       (slot_addr),
    .slot_be_o         (slot_be),
    .slot_wdata_o      (slot_wdata),
    .slot_trans_id_o   (slot_trans_id),
    .slot_misaligned_o (slot_misaligned)
  );

  lsu_mem_ctrl u_mem_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .slot_valid_i      (slot_valid),
    .slot_op_i         (slot_op),
    .slot_addr_i       (slot_addr),
    .slot_be_i         (slot_be),
    .slot_wdata_i      (slot_wdata),
    .slot_trans_id_i   (slot_trans_id),
    .slot_misaligned_i (slot_misaligned),
    .mem_ack_i         (mem_ack_i),
    .mem_rdata_i       (mem_rdata_i),
    .take_o            (take),
    .mem_req_o         (mem_req_o),
    .mem_we_o          (mem_we_o),
    .mem_addr_o        (mem_addr_o),
    .mem_be_o          (mem_be_o),
    .mem_wdata_o       (mem_wdata_o),
    .load_valid_o      (load_valid_o),
    .load_ex_o         (load_ex_o),
    .load_trans_id_o   (load_trans_id_o),
    .load_result_o     (load_result_o),
    .store_valid_o     (store_valid_o),
    .store_ex_o        (store_ex_o),
    .store_trans_id_o  (store_trans_id_o),
    .store_result_o    (store_result_o)
  );

endmodule

// File: test/lsu_properties.sv
`timescale 1ns/1ns

module lsu_properties (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic                      mem_req_o,
  input logic                      mem_ack_i,
  input logic                      mem_we_o,
  input logic [lsu_pkg::XLEN-1:0]  mem_addr_o,
  input logic [lsu_pkg::NBYTES-1:0] mem_be_o,
  input logic [lsu_pkg::XLEN-1:0]  mem_wdata_o,
  input logic                      load_valid_o,
  input logic                      store_valid_o
);

  // Req stays up until the memory answers
  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
      mem_req_o && !mem_ack_i |=> mem_req_o)
    else $error("mem_req_o dropped before mem_ack_i");

  req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      mem_req_o && !mem_ack_i |=> $stable({mem_we_o, mem_addr_o, mem_be_o, mem_wdata_o}))
    else $error("memory request signals changed while mem_req_o was high");

  // Previous transfer must be fully closed
  no_req_on_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !mem_req_o && mem_ack_i |=> !mem_req_o)
    else $error("mem_req_o rose while mem_ack_i was high");

  one_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !(load_valid_o && store_valid_o))
    else $error("load_valid_o and store_valid_o pulsed together");

endmodule

bind lsu_mem_ctrl lsu_properties u_properties (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .mem_req_o     (mem_req_o),
  .mem_ack_i     (mem_ack_i),
  .mem_we_o      (mem_we_o),
  .mem_addr_o    (mem_addr_o),
  .mem_be_o      (mem_be_o),
  .mem_wdata_o   (mem_wdata_o),
  .load_valid_o  (load_valid_o),
  .store_valid_o (store_valid_o)
);

// File: test/tb_lsu.sv
`timescale 1ns/1ns

module tb_lsu;

  import lsu_pkg::*;

  localparam int TIMEOUT_CYCLES = 100;

  typedef struct packed {
    logic        is_store;
    logic        ex;
    logic        timed;
    logic [2:0]  id;
    logic [31:0] result;
    logic [31:0] acc_cycle;
  } exp_t;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic lsu_valid_i, lsu_ready_o;
  lsu_op_e op_i;
  logic [31:0] operand_a_i, imm_i, operand_b_i;
  logic [2:0] trans_id_i;
  logic mem_req_o, mem_we_o, mem_ack_i;
  logic [31:0] mem_addr_o, mem_wdata_o, mem_rdata_i;
  logic [3:0] mem_be_o;
  logic load_valid_o, load_ex_o, store_valid_o, store_ex_o;
  logic [2:0] load_trans_id_o, store_trans_id_o;
  logic [31:0] load_result_o, store_result_o;

  logic [31:0] mem [64];
  logic [31:0] model_mem [64];
  exp_t exp_q[$];
  integer seed = 39572;
  logic [31:0] cycle = 0;
  logic [2:0] next_id = 0;
  logic slow_ack = 1'b0;
  logic saw_not_ready = 1'b0;
  int max_outstanding = 0;
  int transfers = 0;
  int issued = 0;
  int returned = 0;
  int checks = 0;
  int errors = 0;
  int errors_at_start = 0;
  int tests = 0;
  int failed_tests = 0;

  lsu_top u_dut (.*);

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) cycle <= cycle + 1;

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic int access_bytes(input lsu_op_e op);
    if (op inside {LB, LBU, SB}) return 1;
    if (op inside {LH, LHU, SH}) return 2;
    return 4;
  endfunction

  // Lane pick and extension as the ISA defines them
  function automatic logic [31:0] model_load(input lsu_op_e op, input logic [31:0] word,
                                             input logic [1:0] lsb);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[8 * lsb +: 8];
    h = lsb[1] ? word[31:16] : word[15:0];
    case (op)
      LB:      return {{24{b[7]}}, b};
      LBU:     return {24'b0, b};
      LH:      return {{16{h[15]}}, h};
      LHU:     return {16'b0, h};
      default: return word;
    endcase
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    checks++;
    assert (got === exp) else begin
      $display("error at %0t ns: %s got %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors == errors_at_start) begin
      $display("Test %0d %s: passed", tests, name);
    end else begin
      $display("Test %0d %s: failed", tests, name);
      failed_tests++;
    end
    errors_at_start = errors;
  endtask

  // --------------------------------------------------------------------------
  // Issue side and reference model
  // --------------------------------------------------------------------------
  task automatic issue(input lsu_op_e op, input logic [31:0] a, input logic [31:0] imm,
                       input logic [31:0] b, input logic timed);
    logic [31:0] addr;
    logic [5:0]  idx;
    exp_t        e;
    int          nb;
    int          waited;
    addr = a + imm;
    idx = addr[7:2];
    nb = access_bytes(op);
    op_i = op;
    operand_a_i = a;
    imm_i = imm;
    operand_b_i = b;
    trans_id_i = next_id;
    lsu_valid_i = 1'b1;
    waited = 0;
    while (!lsu_ready_o && waited < TIMEOUT_CYCLES) begin
      saw_not_ready = 1'b1;
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (!lsu_ready_o) begin
      $display("Timeout: request with trans_id %0d was never accepted", next_id);
      errors++;
    end else begin
      @(posedge clk_i);
      #1;
      e.is_store = op inside {SB, SH, SW};
      e.ex = (nb == 2 && addr[0]) || (nb == 4 && addr[1:0] != 2'b00);
      e.timed = timed;
      e.id = next_id;
      e.acc_cycle = cycle;
      if (e.ex) begin
        e.result = addr;
      end else if (e.is_store) begin
        for (int k = 0; k < nb; k++) begin
          model_mem[idx][8 * (addr[1:0] + k) +: 8] = b[8 * k +: 8];
        end
        e.result = 32'b0;
      end else begin
        e.result = model_load(op, model_mem[idx], addr[1:0]);
      end
      exp_q.push_back(e);
      if (exp_q.size() > max_outstanding) max_outstanding = exp_q.size();
      issued++;
      next_id++;
    end
    lsu_valid_i = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout: %0d results never came back", exp_q.size());
      errors++;
      exp_q.delete();
    end
  endtask

  // --------------------------------------------------------------------------
  // Memory responder, four-phase
  // --------------------------------------------------------------------------
  always begin : responder
    int         delay;
    int         waited;
    logic [5:0] idx;
    @(posedge clk_i);
    #1;
    if (rst_ni && mem_req_o && !mem_ack_i) begin
      transfers++;
      delay = slow_ack ? 5 : int'(rand_below(6));
      repeat (delay) begin
        @(posedge clk_i);
        #1;
      end
      check_value(32'(mem_addr_o[1:0]), 32'd0, "mem_addr_o low bits");
      idx = mem_addr_o[7:2];
      if (mem_we_o) begin
        for (int k = 0; k < 4; k++) begin
          if (mem_be_o[k]) mem[idx][8 * k +: 8] = mem_wdata_o[8 * k +: 8];
        end
      end
      mem_rdata_i = mem[idx];
      mem_ack_i = 1'b1;
      waited = 0;
      while (mem_req_o && waited < TIMEOUT_CYCLES) begin
        @(posedge clk_i);
        #1;
        waited++;
      end
      if (mem_req_o) begin
        $display("Timeout: mem_req_o stayed high after mem_ack_i");
        errors++;
      end
      mem_ack_i = 1'b0;
    end
  end

  // Results sampled mid-cycle
  always @(negedge clk_i) begin : monitor
    exp_t e;
    if (rst_ni && (load_valid_o || store_valid_o)) begin
      returned++;
      if (exp_q.size() == 0) begin
        $display("Result pulse at %0t ns with no request outstanding", $time);
        errors++;
      end else begin
        e = exp_q.pop_front();
        check_value(32'(store_valid_o), 32'(e.is_store), "store_valid_o");
        if (store_valid_o) begin
          check_value(32'(store_ex_o), 32'(e.ex), "store_ex_o");
          check_value(32'(store_trans_id_o), 32'(e.id), "store_trans_id_o");
          check_value(store_result_o, e.result, "store_result_o");
        end else begin
          check_value(32'(load_ex_o), 32'(e.ex), "load_ex_o");
          check_value(32'(load_trans_id_o), 32'(e.id), "load_trans_id_o");
          check_value(load_result_o, e.result, "load_result_o");
        end
        // Pulse is captured at the next rising edge
        if (e.timed) check_value(cycle + 1 - e.acc_cycle, 32'd2, "misaligned latency");
      end
    end
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin : main
    lsu_op_e     op;
    logic [31:0] target;
    logic [31:0] imm;
    int          transfers_before;
    rst_ni = 1'b0;
    lsu_valid_i = 1'b0;
    op_i = LB;
    operand_a_i = 32'b0;
    imm_i = 32'b0;
    operand_b_i = 32'b0;
    trans_id_i = 3'b0;
    mem_ack_i = 1'b0;
    mem_rdata_i = 32'b0;
    for (int i = 0; i < 64; i++) begin
      mem[i] = 32'(i) * 32'h9e37_79b1 + 32'h0bad_0001;
      model_mem[i] = mem[i];
    end

    repeat (2) @(posedge clk_i);
    check_value(32'(lsu_ready_o), 32'd0, "lsu_ready_o in reset");
    #1;
    rst_ni = 1'b1;
    for (int n = 0; n < 3; n++) begin
      @(posedge clk_i);
      #1;
      check_value(32'({mem_req_o, load_valid_o, store_valid_o, load_ex_o, store_ex_o}),
                  32'd0, "outputs after reset");
    end
    check_value(32'(lsu_ready_o), 32'd1, "lsu_ready_o after reset");
    finish_test("reset state");

    issue(SW, 32'h40, 32'h0, 32'h8091_a2b3, 1'b0);
    issue(SB, 32'h50, 32'hffff_fff1, 32'h0000_00c5, 1'b0);
    issue(SH, 32'h44, 32'h2, 32'h1234_f00d, 1'b0);
    issue(LB, 32'h41, 32'h0, 32'h0, 1'b0);
    issue(LBU, 32'h41, 32'h0, 32'h0, 1'b0);
    issue(LH, 32'h40, 32'h6, 32'h0, 1'b0);
    issue(LHU, 32'h46, 32'h0, 32'h0, 1'b0);
    issue(LW, 32'h40, 32'h0, 32'h0, 1'b0);
    issue(LB, 32'h43, 32'h0, 32'h0, 1'b0);
    issue(LH, 32'h42, 32'h0, 32'h0, 1'b0);
    issue(LW, 32'h48, 32'hffff_fffc, 32'h0, 1'b0);
    drain();
    finish_test("aligned stores and loads");

    // Each one alone so the sequencer is idle at acceptance
    transfers_before = transfers;
    drain();
    issue(LH, 32'h20, 32'h1, 32'h0, 1'b1);
    drain();
    issue(SH, 32'h23, 32'h0, 32'h5555, 1'b1);
    drain();
    issue(LHU, 32'h25, 32'h0, 32'h0, 1'b1);
    drain();
    issue(LW, 32'h22, 32'h0, 32'h0, 1'b1);
    drain();
    issue(SW, 32'h40, 32'h1, 32'h1234_5678, 1'b1);
    drain();
    issue(LW, 32'h43, 32'h0, 32'h0, 1'b1);
    drain();
    check_value(32'(transfers), 32'(transfers_before), "memory transfers for misaligned");
    finish_test("misaligned accesses");

    max_outstanding = 0;
    for (int n = 0; n < 300; n++) begin
      op = lsu_op_e'(4'(rand_below(8)));
      target = 32'(rand_below(256));
      imm = 32'(rand_below(32)) - 32'd16;
      issue(op, target - imm, imm, $random(seed), 1'b0);
      if (rand_below(4) == 0) begin
        @(posedge clk_i);
        #1;
      end
    end
    drain();
    check_value(32'(returned), 32'(issued), "results returned");
    check_value(32'(max_outstanding <= 2), 32'd1, "at most two outstanding");
    finish_test("random mix");

    slow_ack = 1'b1;
    saw_not_ready = 1'b0;
    max_outstanding = 0;
    for (int n = 0; n < 6; n++) begin
      issue((n % 2 == 0) ? SW : LW, 32'(8 * n), 32'h0, $random(seed), 1'b0);
    end
    drain();
    slow_ack = 1'b0;
    check_value(32'(saw_not_ready), 32'd1, "lsu_ready_o low under slow ack");
    check_value(32'(max_outstanding), 32'd2, "outstanding under slow ack");
    finish_test("back-pressure");

    $display("Tests: %0d, failed tests: %0d, checks: %0d, errors: %0d",
             tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: lsu_lite.f
design/lsu_pkg.sv
design/lsu_load_align.sv
design/lsu_agu.sv
design/lsu_mem_ctrl.sv
design/lsu_top.sv
test/lsu_properties.sv
test/tb_lsu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the LSU testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
    --top-module tb_lsu -f lsu_lite.f -o tb_lsu_sim; then
  echo "Verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/tb_lsu_sim)
sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^Finished with no errors$" <<< "$sim_output"; then
  exit 0
else
  echo "Pass message not found in simulation output"
  exit 1
fi
